//--- bandRender/bandRender.sv
/*
 * Label band renderer: finds the present wire whose colour band covers the pixel
 * and reports its palette index and dimming. One registered stage.
 */
`timescale 1ns/1ps

module bandRender #(
    parameter int numWires = 6
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  wirePanelPkg::pixelPos_t  pos,
    input  wirePanelPkg::wireState_t state,
    output wirePanelPkg::bandLayer_t bandLayer
);
    import wirePanelPkg::*;

    logic       inBandRows;
    bandLayer_t bandNext;

    assign inBandRows = inRows(pos.y, BAND_TOP, WIRE_TOP);  // band sits right above the wires

    always_comb begin
        bandNext = '0;
        if (inBandRows) begin
            // bands share the wire columns, so one slot matches at most
            for (int i = 0; i < numWires; i++) begin
                if (i < int'(state.wireCount) && inSlotX(pos.x, i, 0)) begin
                    bandNext.bandHit   = 1'b1;
                    bandNext.bandColor = state.wireColor[i];
                    bandNext.bandDim   = state.wireCut[i];   // a cut wire gets a dim label
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            bandLayer <= '0;
        end else begin
            bandLayer <= bandNext;
        end
    end

endmodule

//--- common/wirePanelPkg.sv
/*
 * Shared geometry, pixel types and palettes of the wire panel display.
 * Every RTL block of the panel pipeline imports it.
 */
package wirePanelPkg;

    // screen layout in pixels
    localparam int MAX_WIRES       = 6;
    localparam int SCREEN_WIDTH    = 240;
    localparam int MARGIN          = 40;
    localparam int SPACE           = 20;     // empty columns between two wires
    localparam int WIRE_LENGTH     = 10;     // horizontal width of one wire
    localparam int WIRE_HEIGHT     = 120;
    localparam int WIRE_CUT_HEIGHT = 40;     // solid part kept at each end of a cut wire
    localparam int BAND_HEIGHT     = 20;
    localparam int HIGHLIGHT       = 3;      // frame width on each side of the selected wire

    // derived bounds, every one of them is compared strictly
    localparam int SLOT_PITCH  = WIRE_LENGTH + SPACE;
    localparam int BAND_TOP    = MARGIN;
    localparam int WIRE_TOP    = MARGIN + BAND_HEIGHT;
    localparam int WIRE_BOTTOM = WIRE_TOP + WIRE_HEIGHT;
    localparam int GAP_TOP     = WIRE_TOP + WIRE_CUT_HEIGHT;
    localparam int GAP_BOTTOM  = WIRE_BOTTOM - WIRE_CUT_HEIGHT;

    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
    } pixelPos_t;

    typedef struct packed {
        logic [2:0]                wireCount;     // wires present, slots 0 up to this count
        logic [MAX_WIRES-1:0]      wireCut;       // one bit per slot
        logic [2:0]                selectedWire;
        logic [MAX_WIRES-1:0][2:0] wireColor;     // palette index of each slot
    } wireState_t;

    typedef struct packed {
        logic [MAX_WIRES-1:0] wireHit;            // at most one bit is set, slots never overlap
        logic                 highlight;
    } wireLayer_t;

    typedef struct packed {
        logic       bandHit;
        logic [2:0] bandColor;
        logic       bandDim;                      // band of a cut wire
    } bandLayer_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb12_t;

    // red, green, blue, yellow, cyan, magenta, orange, pink
    localparam rgb12_t PALETTE [8] = '{
        12'hF00, 12'h0F0, 12'h00F, 12'hFF0, 12'h0FF, 12'hF0F, 12'hF80, 12'hF8C
    };

    // each channel of PALETTE halved
    localparam rgb12_t DIM_PALETTE [8] = '{
        12'h700, 12'h070, 12'h007, 12'h770, 12'h077, 12'h707, 12'h740, 12'h746
    };

    localparam rgb12_t HIGHLIGHT_COLOR  = 12'hFFF;
    localparam rgb12_t BACKGROUND_COLOR = 12'h222;

    // x strictly inside the slot's column range, widened by widen on both sides
    function automatic logic inSlotX(input logic [8:0] x, input int slot, input int widen);
        int right;
        int left;
        right = SCREEN_WIDTH - (MARGIN + slot * SLOT_PITCH);
        left  = right - WIRE_LENGTH;
        return (int'(x) > left - widen) && (int'(x) < right + widen);
    endfunction

    // y strictly between top and bottom
    function automatic logic inRows(input logic [7:0] y, input int top, input int bottom);
        return (int'(y) > top) && (int'(y) < bottom);
    endfunction

endpackage

//--- hdl/pixelCompose.sv
/*
 * Final colour stage: merges the wire and band layers by priority and looks the
 * result up in the palettes. Registered, one cycle.
 */
`timescale 1ns/1ps

module pixelCompose #(
    parameter int numWires = 6
) (
    input  logic                                        clk,
    input  logic                                        nrst,
    input  wirePanelPkg::wireLayer_t                    wireLayer,
    input  wirePanelPkg::bandLayer_t                    bandLayer,
    input  logic [wirePanelPkg::MAX_WIRES-1:0][2:0]     wireColor,
    output wirePanelPkg::rgb12_t                        pixel
);
    import wirePanelPkg::*;

    logic       anyWire;
    logic [2:0] wireIdx;
    rgb12_t     bandRgb;
    rgb12_t     pixelNext;

    assign anyWire = |wireLayer.wireHit;

    // the renderer sets at most one hit bit, so the last match is the only one
    always_comb begin
        wireIdx = '0;
        for (int i = 0; i < numWires; i++) begin
            if (wireLayer.wireHit[i]) begin
                wireIdx = wireColor[i];
            end
        end
    end

    assign bandRgb = bandLayer.bandDim ? DIM_PALETTE[bandLayer.bandColor]
                                       : PALETTE[bandLayer.bandColor];

    // wire over highlight over band over background
    always_comb begin
        if (anyWire) begin
            pixelNext = PALETTE[wireIdx];
        end else if (wireLayer.highlight) begin
            pixelNext = HIGHLIGHT_COLOR;
        end else if (bandLayer.bandHit) begin
            pixelNext = bandRgb;
        end else begin
            pixelNext = BACKGROUND_COLOR;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pixel <= '0;     // black until the pipeline runs
        end else begin
            pixel <= pixelNext;
        end
    end

endmodule

//--- hdl/wirePanel.sv
/*
 * Top level of the wire panel display. Takes one pixel coordinate and game state per
 * clock and returns its 12-bit colour three registers later.
 */
`timescale 1ns/1ps

module wirePanel #(
    parameter int numWires   = wirePanelPkg::MAX_WIRES,
    parameter int frameWidth = wirePanelPkg::HIGHLIGHT
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  wirePanelPkg::pixelPos_t  pos,
    input  wirePanelPkg::wireState_t state,
    output wirePanelPkg::rgb12_t     pixel
);
    import wirePanelPkg::*;

    pixelPos_t                 posQ;
    wireState_t                stateQ;
    logic [MAX_WIRES-1:0][2:0] colorQ;      // wire colours lined up with the layer stage
    wireLayer_t                wireLayer;
    bandLayer_t                bandLayer;

    // input stage, then the colour copy trails it by one cycle
    always_ff @(posedge clk) begin
        posQ   <= pos;
        stateQ <= state;
        colorQ <= stateQ.wireColor;
    end

    wireRender #(
        .numWires   (numWires),
        .frameWidth (frameWidth)
    ) wireRender_i (
        .clk       (clk),
        .nrst      (nrst),
        .pos       (posQ),
        .state     (stateQ),
        .wireLayer (wireLayer)
    );

    bandRender #(
        .numWires (numWires)
    ) bandRender_i (
        .clk       (clk),
        .nrst      (nrst),
        .pos       (posQ),
        .state     (stateQ),
        .bandLayer (bandLayer)
    );

    pixelCompose #(
        .numWires (numWires)
    ) pixelCompose_i (
        .clk       (clk),
        .nrst      (nrst),
        .wireLayer (wireLayer),
        .bandLayer (bandLayer),
        .wireColor (colorQ),
        .pixel     (pixel)
    );

endmodule

//--- sources.f
common/wirePanelPkg.sv
wireRender/wireRender.sv
bandRender/bandRender.sv
hdl/pixelCompose.sv
hdl/wirePanel.sv
test/wirePanel_checker.sv
test/wirePanelTb.sv

//--- test/wirePanelTb.sv
/*
 * Testbench of the wire panel display: sweeps and random pixels through the DUT and
 * compares every colour with a model of the panel geometry, three edges later.
 */
`timescale 1ns/1ps

module wirePanelTb;
    import wirePanelPkg::*;

    // panel geometry in pixels with strict bounds
    localparam int firstRight = 200;     // right edge of slot 0
    localparam int pitch      = 30;
    localparam int wireWidth  = 10;
    localparam int frame      = 3;
    localparam int bandTop    = 40;
    localparam int wireTop    = 60;
    localparam int wireBottom = 180;
    localparam int gapTop     = 100;
    localparam int gapBottom  = 140;
    localparam int drainLimit = 20;

    typedef struct packed {
        logic      check;                // cleared for filler entries after the stimulus
        pixelPos_t pos;
        rgb12_t    expected;
    } inFlight_t;

    logic       clk;
    logic       nrst;
    pixelPos_t  pos;
    wireState_t state;
    rgb12_t     pixel;
    logic       stimDone = 1'b0;
    inFlight_t  inFlight[$];
    int         pending    = 0;
    int         checkCount = 0;
    int         errCount   = 0;

    wirePanel dut_i (
        .clk   (clk),
        .nrst  (nrst),
        .pos   (pos),
        .state (state),
        .pixel (pixel)
    );

    bind wirePanel wirePanel_checker checker_i (
        .clk   (clk),
        .nrst  (nrst),
        .pos   (pos),
        .state (state),
        .pixel (pixel)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int slotRight(input int slot);
        return firstRight - pitch * slot;
    endfunction

    // expected colour of one pixel from the geometry and priority rules
    function automatic rgb12_t modelPixel(input pixelPos_t p, input wireState_t s);
        int     x;
        int     y;
        int     right;
        rgb12_t result;
        x      = int'(p.x);
        y      = int'(p.y);
        result = BACKGROUND_COLOR;
        if (y > bandTop && y < wireTop) begin
            for (int i = 0; i < MAX_WIRES && i < int'(s.wireCount); i++) begin
                right = slotRight(i);
                if (x > right - wireWidth && x < right) begin
                    result = s.wireCut[i] ? DIM_PALETTE[s.wireColor[i]] : PALETTE[s.wireColor[i]];
                end
            end
        end
        if (y > wireTop && y < wireBottom) begin
            right = slotRight(int'(s.selectedWire));
            if (s.selectedWire < s.wireCount && x > right - wireWidth - frame
                    && x < right + frame) begin
                result = HIGHLIGHT_COLOR;    // wire pixels below still win over the frame
            end
            for (int i = 0; i < MAX_WIRES && i < int'(s.wireCount); i++) begin
                right = slotRight(i);
                if (x > right - wireWidth && x < right
                        && !(s.wireCut[i] && y > gapTop && y < gapBottom)) begin
                    result = PALETTE[s.wireColor[i]];
                end
            end
        end
        return result;
    endfunction

    function automatic wireState_t randomState(input int count);
        wireState_t s;
        s.wireCount    = count[2:0];
        s.wireCut      = 6'($urandom);
        s.selectedWire = 3'($urandom_range(5, 0));
        for (int i = 0; i < MAX_WIRES; i++) begin
            s.wireColor[i] = 3'($urandom);
        end
        return s;
    endfunction

    task automatic driveCoord(input int x, input int y, input wireState_t st);
        @(posedge clk);
        pos.x <= x[8:0];
        pos.y <= y[7:0];
        state <= st;
    endtask

    task automatic rowSweep(input int y, input wireState_t st);
        for (int x = 0; x < SCREEN_WIDTH; x++) begin
            driveCoord(x, y, st);
        end
    endtask

    // every wire count with uncut wires over the wire rows and their edges
    task automatic wireCountSweep();
        wireState_t st;
        for (int count = 0; count <= MAX_WIRES; count++) begin
            st         = randomState(count);
            st.wireCut = '0;
            rowSweep(wireTop, st);
            rowSweep(wireTop + 1, st);
            rowSweep(gapTop + 10, st);
            rowSweep(wireBottom - 1, st);
        end
    endtask

    task automatic cutGapSweep();
        wireState_t st;
        for (int n = 0; n < 4; n++) begin
            st = randomState(MAX_WIRES);
            rowSweep(70, st);
            rowSweep(gapTop, st);
            rowSweep(gapTop + 1, st);
            rowSweep(120, st);
            rowSweep(gapBottom - 1, st);
            rowSweep(gapBottom, st);
        end
    endtask

    // each selected slot once present and once absent
    task automatic highlightSweep();
        wireState_t st;
        for (int sel = 0; sel < MAX_WIRES; sel++) begin
            st              = randomState(MAX_WIRES);
            st.selectedWire = sel[2:0];
            rowSweep(wireTop + 1, st);
            rowSweep(120, st);
            st.wireCount    = sel[2:0];
            rowSweep(wireTop + 1, st);
        end
    endtask

    task automatic bandSweep();
        for (int n = 0; n < 4; n++) begin
            rowSweep(bandTop, randomState($urandom_range(MAX_WIRES, 0)));
            rowSweep(bandTop + 1, randomState(MAX_WIRES));
            rowSweep(50, randomState(MAX_WIRES));
            rowSweep(wireTop - 1, randomState($urandom_range(MAX_WIRES, 0)));
            rowSweep(wireTop, randomState(MAX_WIRES));
        end
    endtask

    task automatic randomStream(input int count);
        for (int n = 0; n < count; n++) begin
            driveCoord($urandom_range(255, 0), $urandom_range(255, 0),
                       randomState($urandom_range(MAX_WIRES, 0)));
        end
    endtask

    // inputs are read between edges and their result comes out three edges later
    always @(negedge clk) begin
        inFlight_t entry;
        if (!nrst) begin
            inFlight.delete();
            pending = 0;
        end else begin
            if (inFlight.size() == 3) begin
                entry = inFlight.pop_front();
                if (entry.check) begin
                    checkCount++;
                    pending--;
                    assert (pixel === entry.expected) else begin
                        errCount++;
                        $display("Error: pixel is %h, expected %h at pos x=%h y=%h",
                                 pixel, entry.expected, entry.pos.x, entry.pos.y);
                    end
                end
            end
            entry.check    = !stimDone;
            entry.pos      = pos;
            entry.expected = modelPixel(pos, state);
            inFlight.push_back(entry);
            if (!stimDone) begin
                pending++;
            end
        end
    end

    initial begin
        int guard;
        void'($urandom(32'h5f34_89d9));
        nrst  = 1'b0;
        pos   = '0;
        state = '0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        wireCountSweep();
        cutGapSweep();
        highlightSweep();
        bandSweep();
        randomStream(3000);

        @(posedge clk);
        stimDone = 1'b1;
        guard    = 0;
        while (pending > 0 && guard < drainLimit) begin
            @(posedge clk);
            guard++;
        end

        $display("Checks: %0d, pixel mismatches: %0d, checker failures: %0d",
                 checkCount, errCount, dut_i.checker_i.failCount);
        if (pending > 0) begin
            $display("Timeout: %0d results never left the pipeline", pending);
            $display("TESTS FAILED");
        end else if (errCount == 0 && dut_i.checker_i.failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/wirePanel_checker.sv
/*
 * Concurrent checks on the wire panel ports, bound into the top level.
 * Covers reset, the three-edge latency and the wire colour priority.
 */
`timescale 1ns/1ps

module wirePanel_checker (
    input logic                     clk,
    input logic                     nrst,
    input wirePanelPkg::pixelPos_t  pos,
    input wirePanelPkg::wireState_t state,
    input wirePanelPkg::rgb12_t     pixel
);
    import wirePanelPkg::*;

    localparam int firstRight = 200;
    localparam int pitch      = 30;
    localparam int wireWidth  = 10;
    localparam int bandTop    = 40;
    localparam int wireTop    = 60;
    localparam int wireBottom = 180;
    localparam int gapTop     = 100;
    localparam int gapBottom  = 140;

    int     failCount = 0;   // failed assertion attempts so far
    int     slot;
    logic   onWire;
    rgb12_t wireRgb;

    // slot whose column holds x or -1 between and beside the wires
    function automatic int slotUnder(input logic [8:0] x);
        int right;
        int found;
        found = -1;
        for (int i = 0; i < MAX_WIRES; i++) begin
            right = firstRight - pitch * i;
            if (int'(x) > right - wireWidth && int'(x) < right) begin
                found = i;
            end
        end
        return found;
    endfunction

    always_comb begin
        slot    = slotUnder(pos.x);
        onWire  = 1'b0;
        wireRgb = BACKGROUND_COLOR;
        if (slot >= 0 && slot < int'(state.wireCount) && pos.y > wireTop && pos.y < wireBottom) begin
            onWire  = !(state.wireCut[slot] && pos.y > gapTop && pos.y < gapBottom);
            wireRgb = PALETTE[state.wireColor[slot]];
        end
    end

    resetClears: assert property (@(posedge clk) !nrst |=> pixel == '0)
        else begin
            failCount++;
            $error("pixel is %h after a reset edge, expected 000", $sampled(pixel));
        end

    // nothing is drawn above the band or below the wires
    backgroundOutsideRows: assert property (@(posedge clk) disable iff (!nrst)
        (pos.y <= bandTop || pos.y >= wireBottom) |-> ##3 pixel == BACKGROUND_COLOR)
        else begin
            failCount++;
            $error("pixel is %h, expected background %h", $sampled(pixel), BACKGROUND_COLOR);
        end

    wireNeverHighlighted: assert property (@(posedge clk) disable iff (!nrst)
        onWire |-> ##3 pixel != HIGHLIGHT_COLOR)
        else begin
            failCount++;
            $error("pixel is %h, the highlight colour drawn over a wire", $sampled(pixel));
        end

    wireShowsPalette: assert property (@(posedge clk) disable iff (!nrst)
        onWire |-> ##3 pixel == $past(wireRgb, 3))
        else begin
            failCount++;
            $error("pixel is %h, not the palette colour of the wire", $sampled(pixel));
        end

endmodule

//--- wireRender/wireRender.sv
/*
 * Wire layer renderer: flags the wire slot under the current pixel, with cut gaps,
 * and the highlight frame around the selected wire. One registered stage.
 */
`timescale 1ns/1ps

module wireRender #(
    parameter int numWires   = 6,
    parameter int frameWidth = 3
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  wirePanelPkg::pixelPos_t  pos,
    input  wirePanelPkg::wireState_t state,
    output wirePanelPkg::wireLayer_t wireLayer
);
    import wirePanelPkg::*;

    logic                 inWireRows;
    logic                 inGapRows;
    logic                 selPresent;
    logic                 inFrame;
    logic [MAX_WIRES-1:0] hitNext;
    logic                 highlightNext;

    // row tests are shared by all slots
    assign inWireRows = inRows(pos.y, WIRE_TOP, WIRE_BOTTOM);
    assign inGapRows  = inRows(pos.y, GAP_TOP, GAP_BOTTOM);

    always_comb begin
        hitNext = '0;
        for (int i = 0; i < numWires; i++) begin
            // slots at or above wireCount stay empty
            if (i < int'(state.wireCount) && inWireRows && inSlotX(pos.x, i, 0)) begin
                hitNext[i] = !(state.wireCut[i] && inGapRows);  // cut wires lose the middle
            end
        end
    end

    // the frame needs a wire actually present in the selected slot
    assign selPresent = state.selectedWire < state.wireCount;

    // widened rectangle of the selected slot over the wire rows
    assign inFrame = inWireRows && inSlotX(pos.x, int'(state.selectedWire), frameWidth);

    // the frame only shows where no wire pixel is drawn, the gap of a cut wire included
    assign highlightNext = selPresent && inFrame && !(|hitNext);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wireLayer <= '0;
        end else begin
            wireLayer.wireHit   <= hitNext;
            wireLayer.highlight <= highlightNext;
        end
    end

endmodule
